//--- common/isa_pkg.sv
package isa_pkg;

    localparam int word_w = 16;
    localparam int opcode_w = 4;
    localparam int reg_idx_w = 2;
    localparam int func_w = 6;
    localparam int imm_w = 8;

    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // Only the listed opcodes are executed. Every other value is a bubble.
    typedef enum logic [opcode_w-1:0] {
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_RTYPE = 4'd15
    } opcode_t;

    typedef enum logic [func_w-1:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7
    } func_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        func_t    func;
    } instr_r_t;

    typedef struct packed {
        opcode_t          opcode;
        reg_idx_t         rs;
        reg_idx_t         rt;
        logic [imm_w-1:0] imm;
    } instr_i_t;

    // Both views cover the same 16 bits; the opcode field lines up in each.
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

//--- common/pipe_pkg.sv
package pipe_pkg;

    typedef logic [isa_pkg::word_w-1:0] word_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR
    } alu_op_t;

    // The operand B source travels on the use_imm line.
    localparam logic OPB_REG = 1'b0;
    localparam logic OPB_IMM = 1'b1;

endpackage

//--- decode/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  isa_pkg::instr_u   instr,
    input  logic              instr_valid,
    output logic              dec_valid,
    output isa_pkg::reg_idx_t rs_idx,
    output isa_pkg::reg_idx_t rt_idx,
    output isa_pkg::reg_idx_t rd_idx,
    output pipe_pkg::alu_op_t alu_op,
    output logic              use_imm,
    output pipe_pkg::word_t   imm
);

    pipe_pkg::word_t imm_sext;
    pipe_pkg::word_t imm_zext;

    assign imm_sext = {{(isa_pkg::word_w - isa_pkg::imm_w){instr.i.imm[isa_pkg::imm_w-1]}},
                       instr.i.imm};
    assign imm_zext = {{(isa_pkg::word_w - isa_pkg::imm_w){1'b0}}, instr.i.imm};

    // The read indices sit in the same bits for both formats.
    assign rs_idx = instr.r.rs;
    assign rt_idx = instr.r.rt;

    always_comb begin
        dec_valid = 1'b0;
        rd_idx    = instr.r.rd;
        alu_op    = pipe_pkg::ALU_ADD;
        use_imm   = pipe_pkg::OPB_REG;
        imm       = '0;
        case (instr.r.opcode)
            isa_pkg::OP_RTYPE: begin
                dec_valid = instr_valid;
                case (instr.r.func)
                    isa_pkg::FN_ADD: alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUB: alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND: alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::FN_ORR: alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::FN_NOT: alu_op = pipe_pkg::ALU_NOT;
                    isa_pkg::FN_TCP: alu_op = pipe_pkg::ALU_TCP;
                    isa_pkg::FN_SHL: alu_op = pipe_pkg::ALU_SHL;
                    isa_pkg::FN_SHR: alu_op = pipe_pkg::ALU_SHR;
                    default:         dec_valid = 1'b0; // An unknown function is a bubble.
                endcase
            end
            isa_pkg::OP_ADI: begin
                // rs + sext(imm) is issued as rs - (-sext(imm)), leaving ADD for LHI.
                dec_valid = instr_valid;
                rd_idx    = instr.i.rt;
                alu_op    = pipe_pkg::ALU_SUB;
                use_imm   = pipe_pkg::OPB_IMM;
                imm       = '0 - imm_sext;
            end
            isa_pkg::OP_ORI: begin
                dec_valid = instr_valid;
                rd_idx    = instr.i.rt;
                alu_op    = pipe_pkg::ALU_OR;
                use_imm   = pipe_pkg::OPB_IMM;
                imm       = imm_zext;
            end
            isa_pkg::OP_LHI: begin
                dec_valid = instr_valid;
                rd_idx    = instr.i.rt;
                alu_op    = pipe_pkg::ALU_ADD; // Added to zero in the execute unit.
                use_imm   = pipe_pkg::OPB_IMM;
                imm       = {instr.i.imm, {(isa_pkg::word_w - isa_pkg::imm_w){1'b0}}};
            end
            default: begin
                dec_valid = 1'b0;
            end
        endcase
    end

endmodule

//--- decode/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  isa_pkg::reg_idx_t rs_idx,
    input  isa_pkg::reg_idx_t rt_idx,
    output pipe_pkg::word_t   rdata_a,
    output pipe_pkg::word_t   rdata_b,
    input  logic              wb_en,
    input  isa_pkg::reg_idx_t wb_idx,
    input  pipe_pkg::word_t   wb_data
);

    localparam int num_regs = 2 ** isa_pkg::reg_idx_w;

    pipe_pkg::word_t regs [num_regs];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // A write in the same cycle is seen by the reader right away.
    always_comb begin
        if (wb_en && (wb_idx == rs_idx)) begin
            rdata_a = wb_data;
        end else begin
            rdata_a = regs[rs_idx];
        end
        if (wb_en && (wb_idx == rt_idx)) begin
            rdata_b = wb_data;
        end else begin
            rdata_b = regs[rt_idx];
        end
    end

endmodule

//--- rtl/id_ex_stage.sv
`timescale 1ns/100ps

module id_ex_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              valid,
    input  isa_pkg::reg_idx_t rd,
    input  pipe_pkg::alu_op_t alu_op,
    input  logic              use_imm,
    input  pipe_pkg::word_t   imm,
    input  isa_pkg::reg_idx_t src_a_idx,
    input  isa_pkg::reg_idx_t src_b_idx,
    input  pipe_pkg::word_t   op_a,
    input  pipe_pkg::word_t   op_b,
    output logic              ex_valid,
    output isa_pkg::reg_idx_t ex_rd,
    output pipe_pkg::alu_op_t ex_alu_op,
    output logic              ex_use_imm,
    output pipe_pkg::word_t   ex_imm,
    output isa_pkg::reg_idx_t ex_src_a_idx,
    output isa_pkg::reg_idx_t ex_src_b_idx,
    output pipe_pkg::word_t   ex_op_a,
    output pipe_pkg::word_t   ex_op_b
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= valid; // A cycle without a valid instruction becomes a bubble.
        end
    end

    // The source indices stay with the operands so that execute can forward.
    always_ff @(posedge clk) begin
        ex_rd        <= rd;
        ex_alu_op    <= alu_op;
        ex_use_imm   <= use_imm;
        ex_imm       <= imm;
        ex_src_a_idx <= src_a_idx;
        ex_src_b_idx <= src_b_idx;
        ex_op_a      <= op_a;
        ex_op_b      <= op_b;
    end

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ex_valid,
    input  isa_pkg::reg_idx_t ex_rd,
    input  pipe_pkg::alu_op_t ex_alu_op,
    input  logic              ex_use_imm,
    input  pipe_pkg::word_t   ex_imm,
    input  isa_pkg::reg_idx_t ex_src_a_idx,
    input  isa_pkg::reg_idx_t ex_src_b_idx,
    input  pipe_pkg::word_t   ex_op_a,
    input  pipe_pkg::word_t   ex_op_b,
    output logic              wb_en,
    output isa_pkg::reg_idx_t wb_idx,
    output pipe_pkg::word_t   wb_data
);

    pipe_pkg::word_t fwd_a;
    pipe_pkg::word_t fwd_b;
    pipe_pkg::word_t alu_a;
    pipe_pkg::word_t alu_b;
    pipe_pkg::word_t alu_res;
    logic            imm_sel;

    // The instruction ahead has not reached the register file yet.
    assign fwd_a = (wb_en && (wb_idx == ex_src_a_idx)) ? wb_data : ex_op_a;
    assign fwd_b = (wb_en && (wb_idx == ex_src_b_idx)) ? wb_data : ex_op_b;

    assign imm_sel = (ex_use_imm == pipe_pkg::OPB_IMM);
    assign alu_b   = imm_sel ? ex_imm : fwd_b;

    // An immediate add is LHI, which adds its shifted byte to zero.
    assign alu_a = (imm_sel && (ex_alu_op == pipe_pkg::ALU_ADD)) ? '0 : fwd_a;

    always_comb begin
        case (ex_alu_op)
            pipe_pkg::ALU_ADD: alu_res = alu_a + alu_b;
            pipe_pkg::ALU_SUB: alu_res = alu_a - alu_b;
            pipe_pkg::ALU_AND: alu_res = alu_a & alu_b;
            pipe_pkg::ALU_OR:  alu_res = alu_a | alu_b;
            pipe_pkg::ALU_NOT: alu_res = ~alu_a;
            pipe_pkg::ALU_TCP: alu_res = ~alu_a + 1'b1;
            pipe_pkg::ALU_SHL: alu_res = {alu_a[isa_pkg::word_w-2:0], 1'b0};
            pipe_pkg::ALU_SHR: alu_res = {alu_a[isa_pkg::word_w-1], alu_a[isa_pkg::word_w-1:1]};
            default:           alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_idx  <= ex_rd;
        wb_data <= alu_res;
    end

endmodule

//--- rtl/tsc_pipe_top.sv
`timescale 1ns/100ps

module tsc_pipe_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              instr_valid,
    input  isa_pkg::instr_u   instr,
    output logic              result_valid,
    output isa_pkg::reg_idx_t result_rd,
    output pipe_pkg::word_t   result_data
);

    logic              dec_valid;
    isa_pkg::reg_idx_t rs_idx;
    isa_pkg::reg_idx_t rt_idx;
    isa_pkg::reg_idx_t rd_idx;
    pipe_pkg::alu_op_t alu_op;
    logic              use_imm;
    pipe_pkg::word_t   imm;
    pipe_pkg::word_t   rdata_a;
    pipe_pkg::word_t   rdata_b;

    logic              ex_valid;
    isa_pkg::reg_idx_t ex_rd;
    pipe_pkg::alu_op_t ex_alu_op;
    logic              ex_use_imm;
    pipe_pkg::word_t   ex_imm;
    isa_pkg::reg_idx_t ex_src_a_idx;
    isa_pkg::reg_idx_t ex_src_b_idx;
    pipe_pkg::word_t   ex_op_a;
    pipe_pkg::word_t   ex_op_b;

    logic              wb_en;
    isa_pkg::reg_idx_t wb_idx;
    pipe_pkg::word_t   wb_data;

    instr_decoder u_decoder (
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec_valid   (dec_valid),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .rd_idx      (rd_idx),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .imm         (imm)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .wb_en   (wb_en),
        .wb_idx  (wb_idx),
        .wb_data (wb_data)
    );

    id_ex_stage u_id_ex (
        .clk          (clk),
        .arst_n       (arst_n),
        .valid        (dec_valid),
        .rd           (rd_idx),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .imm          (imm),
        .src_a_idx    (rs_idx),
        .src_b_idx    (rt_idx),
        .op_a         (rdata_a),
        .op_b         (rdata_b),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_alu_op    (ex_alu_op),
        .ex_use_imm   (ex_use_imm),
        .ex_imm       (ex_imm),
        .ex_src_a_idx (ex_src_a_idx),
        .ex_src_b_idx (ex_src_b_idx),
        .ex_op_a      (ex_op_a),
        .ex_op_b      (ex_op_b)
    );

    exec_unit u_exec (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_alu_op    (ex_alu_op),
        .ex_use_imm   (ex_use_imm),
        .ex_imm       (ex_imm),
        .ex_src_a_idx (ex_src_a_idx),
        .ex_src_b_idx (ex_src_b_idx),
        .ex_op_a      (ex_op_a),
        .ex_op_b      (ex_op_b),
        .wb_en        (wb_en),
        .wb_idx       (wb_idx),
        .wb_data      (wb_data)
    );

    // The write-back bus is also the result port.
    assign result_valid = wb_en;
    assign result_rd    = wb_idx;
    assign result_data  = wb_data;

endmodule

//--- bench/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1; // The flops leave reset at the following edge.
    end

endmodule

//--- bench/tsc_pipe_chk.sv
`timescale 1ns/100ps

module tsc_pipe_chk (
    input logic            clk,
    input logic            arst_n,
    input logic            instr_valid,
    input isa_pkg::instr_u instr,
    input logic            result_valid
);

    logic supported;

    always_comb begin
        case (instr.r.opcode)
            isa_pkg::OP_ADI, isa_pkg::OP_ORI, isa_pkg::OP_LHI: supported = 1'b1;
            isa_pkg::OP_RTYPE: supported = (instr.r.func <= isa_pkg::FN_SHR);
            default:           supported = 1'b0;
        endcase
    end

    a_quiet_in_reset: assert property (@(posedge clk) !arst_n |=> !result_valid)
        else $error("result_valid is high while arst_n is low");

    // Fixed latency of two cycles from strobe to result.
    a_result_follows: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid && supported |-> ##2 result_valid)
        else $error("No result two cycles after a supported instruction");

    a_bubble_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid && !supported |-> ##2 !result_valid)
        else $error("Result two cycles after an unsupported instruction");

endmodule

bind tsc_pipe_top tsc_pipe_chk u_chk (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid)
);

//--- bench/tb_tsc_pipe.sv
`timescale 1ns/100ps

module tb_tsc_pipe;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 4;
    localparam int n_random     = 400;
    localparam int n_directed   = 60;
    localparam int timeout_ns   = (reset_cycles + n_directed + n_random + 50) * clk_period;

    logic              clk;
    logic              arst_n;
    logic              instr_valid;
    isa_pkg::instr_u   instr;
    logic              result_valid;
    isa_pkg::reg_idx_t result_rd;
    pipe_pkg::word_t   result_data;

    pipe_pkg::word_t   model_regs [4];
    isa_pkg::reg_idx_t exp_rd_q [$];
    pipe_pkg::word_t   exp_data_q [$];
    time               exp_time_q [$];

    tb_clkgen #(
        .half_period  (clk_period / 2),
        .reset_cycles (reset_cycles)
    ) u_clkgen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    tsc_pipe_top u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

    task automatic end_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic report_error(input string why);
        $display("%0t ns: %s", $time, why);
        end_with_failure();
    endtask

    task automatic report_mismatch(input string sig, input pipe_pkg::word_t got,
                                   input pipe_pkg::word_t exp);
        $display("ERR %0t ns %s got 0x%04h expected 0x%04h", $time, sig, got, exp);
        end_with_failure();
    endtask

    function automatic isa_pkg::instr_u r_word(input isa_pkg::func_t fn,
                                               input isa_pkg::reg_idx_t rs,
                                               input isa_pkg::reg_idx_t rt,
                                               input isa_pkg::reg_idx_t rd);
        isa_pkg::instr_u w;
        w.r.opcode = isa_pkg::OP_RTYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.func   = fn;
        return w;
    endfunction

    function automatic isa_pkg::instr_u i_word(input isa_pkg::opcode_t op,
                                               input isa_pkg::reg_idx_t rs,
                                               input isa_pkg::reg_idx_t rt,
                                               input logic [7:0] imm);
        isa_pkg::instr_u w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic isa_pkg::instr_u random_word();
        logic [15:0] raw;
        int          pick;
        int          op;
        raw  = 16'($urandom);
        pick = $urandom_range(0, 99);
        op   = $urandom_range(0, 11);
        if (pick < 45) begin
            raw[15:12] = isa_pkg::OP_RTYPE;
            raw[5:0]   = 6'($urandom_range(0, 7));
        end else if (pick < 60) begin
            raw[15:12] = isa_pkg::OP_ADI;
        end else if (pick < 74) begin
            raw[15:12] = isa_pkg::OP_ORI;
        end else if (pick < 86) begin
            raw[15:12] = isa_pkg::OP_LHI;
        end else if (pick < 93) begin
            raw[15:12] = isa_pkg::OP_RTYPE;
            raw[5:0]   = 6'($urandom_range(8, 63)); // Function codes with no operation.
        end else begin
            raw[15:12] = 4'((op < 4) ? op : op + 3); // Opcodes outside the subset.
        end
        return raw;
    endfunction

    // Architectural effect of one instruction on the four registers.
    task automatic run_model(input isa_pkg::instr_u w, output bit ok,
                             output isa_pkg::reg_idx_t dst, output pipe_pkg::word_t val);
        pipe_pkg::word_t a;
        pipe_pkg::word_t b;
        a   = model_regs[w.r.rs];
        b   = model_regs[w.r.rt];
        ok  = 1'b1;
        dst = w.i.rt;
        val = '0;
        case (w.r.opcode)
            isa_pkg::OP_RTYPE: begin
                dst = w.r.rd;
                case (w.r.func)
                    isa_pkg::FN_ADD: val = a + b;
                    isa_pkg::FN_SUB: val = a - b;
                    isa_pkg::FN_AND: val = a & b;
                    isa_pkg::FN_ORR: val = a | b;
                    isa_pkg::FN_NOT: val = ~a;
                    isa_pkg::FN_TCP: val = -a;
                    isa_pkg::FN_SHL: val = a << 1;
                    isa_pkg::FN_SHR: val = $signed(a) >>> 1; // Sign bit is kept.
                    default:         ok = 1'b0;
                endcase
            end
            isa_pkg::OP_ADI: val = a + {{8{w.i.imm[7]}}, w.i.imm};
            isa_pkg::OP_ORI: val = a | {8'h00, w.i.imm};
            isa_pkg::OP_LHI: val = {w.i.imm, 8'h00};
            default:         ok = 1'b0;
        endcase
        if (ok) begin
            model_regs[dst] = val;
        end
    endtask

    task automatic issue(input logic valid, input isa_pkg::instr_u w);
        bit                ok;
        isa_pkg::reg_idx_t dst;
        pipe_pkg::word_t   val;
        @(posedge clk);
        instr_valid <= valid;
        instr       <= w;
        if (valid) begin
            run_model(w, ok, dst, val);
            if (ok) begin
                exp_rd_q.push_back(dst);
                exp_data_q.push_back(val);
                exp_time_q.push_back($time + 2 * clk_period + clk_period / 2);
            end
        end
    endtask

    // Outputs are sampled mid-cycle, half a period after the result register loads.
    always @(negedge clk) begin
        if (arst_n) begin
            assert (!$isunknown(result_valid))
                else report_error("result_valid is unknown after reset");
            if (result_valid) begin
                assert (exp_rd_q.size() > 0)
                    else report_error("result_valid with no instruction outstanding");
                assert ($time == exp_time_q[0])
                    else report_error($sformatf("result due at %0t ns", exp_time_q[0]));
                assert (result_rd === exp_rd_q[0])
                    else report_mismatch("result_rd", result_rd, exp_rd_q[0]);
                assert (result_data === exp_data_q[0])
                    else report_mismatch("result_data", result_data, exp_data_q[0]);
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_time_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("Timeout after %0d ns, the stimulus did not complete.", timeout_ns);
        end_with_failure();
    end

    initial begin : stimulus
        int seed_ret;
        seed_ret    = $urandom(32'hea4a0704);
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 4; i++) begin
            model_regs[i] = '0;
        end
        wait (arst_n === 1'b1);
        repeat (3) issue(1'b0, random_word());
        issue(1'b1, 16'h0123);
        issue(1'b1, 16'h9abc);
        issue(1'b1, 16'hf6cc); // R-type with function 12.
        repeat (3) issue(1'b0, '0);
        // Each step of this back-to-back chain reads the one before it.
        issue(1'b1, i_word(isa_pkg::OP_LHI, 2'd0, 2'd1, 8'h80));
        issue(1'b1, i_word(isa_pkg::OP_ADI, 2'd1, 2'd2, 8'hff));
        issue(1'b1, i_word(isa_pkg::OP_ORI, 2'd2, 2'd3, 8'hf0));
        issue(1'b1, i_word(isa_pkg::OP_ADI, 2'd3, 2'd0, 8'h7f));
        issue(1'b1, r_word(isa_pkg::FN_ADD, 2'd0, 2'd3, 2'd1));
        issue(1'b1, r_word(isa_pkg::FN_SUB, 2'd1, 2'd0, 2'd1));
        issue(1'b1, r_word(isa_pkg::FN_TCP, 2'd1, 2'd0, 2'd2));
        issue(1'b1, r_word(isa_pkg::FN_SHR, 2'd2, 2'd0, 2'd2));
        issue(1'b1, r_word(isa_pkg::FN_SHL, 2'd2, 2'd0, 2'd2));
        issue(1'b1, r_word(isa_pkg::FN_NOT, 2'd2, 2'd0, 2'd3));
        issue(1'b1, r_word(isa_pkg::FN_AND, 2'd3, 2'd2, 2'd0));
        issue(1'b1, r_word(isa_pkg::FN_ORR, 2'd0, 2'd3, 2'd0));
        issue(1'b0, '0);
        issue(1'b1, r_word(isa_pkg::FN_ADD, 2'd0, 2'd0, 2'd1));
        repeat (n_random) issue(($urandom_range(0, 99) < 70), random_word());
        for (int i = 0; i < 4; i++) begin
            issue(1'b1, i_word(isa_pkg::OP_ORI, 2'(i), 2'(i), 8'h00));
        end
        repeat (4) issue(1'b0, '0);
        @(negedge clk);
        if (exp_rd_q.size() != 0) begin
            report_error($sformatf("%0d expected results never appeared", exp_rd_q.size()));
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- files.f
common/isa_pkg.sv
common/pipe_pkg.sv
decode/instr_decoder.sv
decode/reg_file.sv
rtl/id_ex_stage.sv
rtl/exec_unit.sv
rtl/tsc_pipe_top.sv
bench/tb_clkgen.sv
bench/tsc_pipe_chk.sv
bench/tb_tsc_pipe.sv

//--- Bender.yml
package:
  name: tsc_pipe

sources:
  - common/isa_pkg.sv
  - common/pipe_pkg.sv
  - decode/instr_decoder.sv
  - decode/reg_file.sv
  - rtl/id_ex_stage.sv
  - rtl/exec_unit.sv
  - rtl/tsc_pipe_top.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/tsc_pipe_chk.sv
      - bench/tb_tsc_pipe.sv
